/* run_sim.sh */
#!/bin/sh
# Build and run the sprite display simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module sprite_display_tb -f src.f -o sprite_display_sim

./obj_dir/sprite_display_sim > sim.log
cat sim.log

# The log decides the result
if grep -q "Simulation PASSED" sim.log; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi

/* src.f */
src/sprite_pkg.sv
src/raster_timing.sv
src/sprite_motion.sv
src/sprite_rom.sv
src/sprite_compositor.sv
src/sprite_display_top.sv
verification/sprite_display_tb.sv

/* src/raster_timing.sv */
// VGA raster timing generator
`timescale 1ns/100ps

module raster_timing
    import sprite_pkg::*;
(
    input  logic  pix_clk,
    input  logic  rst_n,
    output beam_t beam,
    output logic  frame_end
);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_last;
    logic       v_last;
    logic       h_in_sync;
    logic       v_in_sync;

    assign h_last = (h_cnt == h_total - 10'd1);
    assign v_last = (v_cnt == v_total - 10'd1);

    // Pixel and line counters
    always_ff @(posedge pix_clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 10'd1;
                end
            end else begin
                h_cnt <= h_cnt + 10'd1;
            end
        end
    end

    assign h_in_sync = (h_cnt >= h_sync_start) && (h_cnt < h_sync_end);
    assign v_in_sync = (v_cnt >= v_sync_start) && (v_cnt < v_sync_end);

    // Decode from the registered counts, sync active low
    always_comb begin
        beam.hcount = h_cnt;
        beam.vcount = v_cnt;
        beam.de     = (h_cnt < h_visible) && (v_cnt < v_visible);
        beam.hsync  = !h_in_sync;
        beam.vsync  = !v_in_sync;
    end

    // First clock of the first blanking line
    assign frame_end = (h_cnt == 10'd0) && (v_cnt == v_visible);

endmodule

/* src/sprite_compositor.sv */
// Sprite compositor
`timescale 1ns/100ps

module sprite_compositor
    import sprite_pkg::*;
(
    input  logic                  pix_clk,
    input  logic                  rst_n,
    input  beam_t                 beam,
    input  logic [9:0]            sprite_x,
    input  logic                  anim_frame,
    output logic [rom_addr_w-1:0] rom_addr,
    input  logic [15:0]           rom_data,
    output video_t                video_out
);

    logic [9:0]       x_end;
    logic [9:0]       y_end;
    logic [9:0]       x_off;
    logic [9:0]       y_off;
    logic             in_win_x;
    logic             in_win_y;
    logic             in_win;
    logic [col_w-1:0] col;
    logic [row_w-1:0] row;

    beam_t            beam_q;
    logic             in_win_q;

    logic [4:0]       r5;
    logic [5:0]       g6;
    logic [4:0]       b5;
    logic [7:0]       r8;
    logic [7:0]       g8;
    logic [7:0]       b8;
    logic             transparent;

    // Stage 1: window test and ROM address
    assign x_end    = sprite_x + scaled_w;
    assign y_end    = sprite_y + scaled_h;
    assign in_win_x = (beam.hcount >= sprite_x) && (beam.hcount < x_end);
    assign in_win_y = (beam.vcount >= sprite_y) && (beam.vcount < y_end);
    assign in_win   = in_win_x && in_win_y;

    assign x_off = beam.hcount - sprite_x;
    assign y_off = beam.vcount - sprite_y;

    // Each sprite pixel covers a scale x scale block
    assign col = x_off[scale_shift +: col_w];
    assign row = y_off[scale_shift +: row_w];

    assign rom_addr = in_win ? {anim_frame, row, col} : '0;

    // Beam travels alongside the ROM read
    always_ff @(posedge pix_clk) begin
        if (!rst_n) begin
            beam_q   <= '{hcount: '0, vcount: '0, de: 1'b0, hsync: 1'b1, vsync: 1'b1};
            in_win_q <= 1'b0;
        end else begin
            beam_q   <= beam;
            in_win_q <= in_win;
        end
    end

    // Stage 2: RGB565 to RGB888 by bit replication
    assign r5 = rom_data[15:11];
    assign g6 = rom_data[10:5];
    assign b5 = rom_data[4:0];

    assign r8 = {r5, r5[4:2]};
    assign g8 = {g6, g6[5:4]};
    assign b8 = {b5, b5[4:2]};

    assign transparent = (rom_data == transparent_key);

    always_ff @(posedge pix_clk) begin
        if (!rst_n) begin
            video_out.x     <= '0;
            video_out.y     <= '0;
            video_out.de    <= 1'b0;
            video_out.hsync <= 1'b1;
            video_out.vsync <= 1'b1;
            video_out.r     <= '0;
            video_out.g     <= '0;
            video_out.b     <= '0;
        end else begin
            video_out.x     <= beam_q.hcount;
            video_out.y     <= beam_q.vcount;
            video_out.de    <= beam_q.de;
            video_out.hsync <= beam_q.hsync;
            video_out.vsync <= beam_q.vsync;

            if (!beam_q.de) begin
                // Black during blanking
                video_out.r <= 8'h00;
                video_out.g <= 8'h00;
                video_out.b <= 8'h00;
            end else if (!in_win_q || transparent) begin
                video_out.r <= bg_r;
                video_out.g <= bg_g;
                video_out.b <= bg_b;
            end else begin
                video_out.r <= r8;
                video_out.g <= g8;
                video_out.b <= b8;
            end
        end
    end

endmodule

/* src/sprite_display_top.sv */
// VGA sprite display top level
`timescale 1ns/100ps

module sprite_display_top
    import sprite_pkg::*;
(
    input  logic   pix_clk,
    input  logic   rst_n,
    output video_t video_out
);

    beam_t                 beam;
    logic                  frame_end;
    logic [9:0]            sprite_x;
    logic                  anim_frame;
    logic [rom_addr_w-1:0] rom_addr;
    logic [15:0]           rom_data;

    raster_timing u_raster_timing (
        .pix_clk   (pix_clk),
        .rst_n     (rst_n),
        .beam      (beam),
        .frame_end (frame_end)
    );

    sprite_motion u_sprite_motion (
        .pix_clk    (pix_clk),
        .rst_n      (rst_n),
        .frame_end  (frame_end),
        .sprite_x   (sprite_x),
        .anim_frame (anim_frame)
    );

    sprite_rom u_sprite_rom (
        .pix_clk  (pix_clk),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    // Two clocks from beam to pixel
    sprite_compositor u_sprite_compositor (
        .pix_clk    (pix_clk),
        .rst_n      (rst_n),
        .beam       (beam),
        .sprite_x   (sprite_x),
        .anim_frame (anim_frame),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .video_out  (video_out)
    );

endmodule

/* src/sprite_frames.hex */
001F FFFF F800 F800 F800 F800 F81F F81F
F81F F800 FFE0 FFE0 FFE0 FFE0 F800 F81F
F800 FFE0 001F FFE0 FFE0 001F FFE0 F800
F800 FFE0 FFE0 8410 FFE0 FFE0 FFE0 F800
F800 FFE0 07E0 FFE0 FFE0 07E0 FFE0 F800
F800 FFE0 FFE0 07E0 07E0 FFE0 FFE0 F800
F81F F800 FFE0 FFE0 FFE0 FFE0 F800 F81F
F81F F81F F800 F800 F800 F800 F81F F81F
FFFF 001F F800 F800 F800 F800 F81F F81F
F81F F800 4A69 4A69 4A69 4A69 F800 F81F
F800 4A69 FFFF 4A69 4A69 FFFF 4A69 F800
F800 4A69 4A69 4A69 4A69 4A69 4A69 F800
F800 4A69 4A69 4A69 4A69 4A69 4A69 F800
F800 4A69 07E0 07E0 07E0 07E0 4A69 F800
F81F F800 4A69 4A69 4A69 4A69 F800 F81F
F81F F81F F800 F800 F800 F800 F81F F81F

/* src/sprite_motion.sv */
// Sprite position and animation control
`timescale 1ns/100ps

module sprite_motion
    import sprite_pkg::*;
(
    input  logic       pix_clk,
    input  logic       rst_n,
    input  logic       frame_end,
    output logic [9:0] sprite_x,
    output logic       anim_frame
);

    motion_state_e         state;
    logic [anim_cnt_w-1:0] anim_cnt;
    logic                  anim_wrap;

    assign anim_wrap = (anim_cnt == anim_cnt_w'(anim_period - 1));

    // Waits for the end of each frame, then takes one step
    always_ff @(posedge pix_clk) begin
        if (!rst_n) begin
            state      <= hold;
            sprite_x   <= x_start;
            anim_frame <= 1'b0;
            anim_cnt   <= '0;
        end else begin
            case (state)
                hold: begin
                    if (frame_end) begin
                        state <= step;
                    end
                end
                step: begin
                    state <= hold;

                    // One pixel left per frame, wrap at the left edge
                    if (sprite_x == 10'd0) begin
                        sprite_x <= x_start;
                    end else begin
                        sprite_x <= sprite_x - 10'd1;
                    end

                    if (anim_wrap) begin
                        anim_cnt   <= '0;
                        anim_frame <= ~anim_frame;
                    end else begin
                        anim_cnt <= anim_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* src/sprite_pkg.sv */
// Sprite display shared definitions
package sprite_pkg;

    // Horizontal timing, 640x480 at 60 Hz
    localparam logic [9:0] h_visible    = 10'd640;
    localparam logic [9:0] h_front      = 10'd16;
    localparam logic [9:0] h_sync       = 10'd96;
    localparam logic [9:0] h_back       = 10'd48;
    localparam logic [9:0] h_total      = h_visible + h_front + h_sync + h_back;
    localparam logic [9:0] h_sync_start = h_visible + h_front;
    localparam logic [9:0] h_sync_end   = h_sync_start + h_sync;

    // Vertical timing in lines
    localparam logic [9:0] v_visible    = 10'd480;
    localparam logic [9:0] v_front      = 10'd10;
    localparam logic [9:0] v_sync       = 10'd2;
    localparam logic [9:0] v_back       = 10'd33;
    localparam logic [9:0] v_total      = v_visible + v_front + v_sync + v_back;
    localparam logic [9:0] v_sync_start = v_visible + v_front;
    localparam logic [9:0] v_sync_end   = v_sync_start + v_sync;

    // Sprite geometry
    localparam int sprite_w     = 8;
    localparam int sprite_h     = 8;
    localparam int sprite_scale = 4;
    localparam int num_frames   = 2;
    localparam int col_w        = $clog2(sprite_w);
    localparam int row_w        = $clog2(sprite_h);
    localparam int scale_shift  = $clog2(sprite_scale);

    localparam logic [9:0] scaled_w = 10'(sprite_w * sprite_scale);
    localparam logic [9:0] scaled_h = 10'(sprite_h * sprite_scale);
    // Centred vertically
    localparam logic [9:0] sprite_y = (v_visible - scaled_h) >> 1;
    // Rightmost position, also the wrap target
    localparam logic [9:0] x_start  = h_visible - scaled_w;

    // Video frames per animation frame
    localparam int anim_period = 8;
    localparam int anim_cnt_w  = $clog2(anim_period);

    // Sprite memory
    localparam int rom_addr_w = 7;
    localparam int rom_words  = num_frames * sprite_w * sprite_h;

    localparam logic [7:0]  bg_r            = 8'h88;
    localparam logic [7:0]  bg_g            = 8'hcc;
    localparam logic [7:0]  bg_b            = 8'h88;
    localparam logic [15:0] transparent_key = 16'hF81F;

    typedef struct packed {
        logic [9:0] hcount;
        logic [9:0] vcount;
        logic       de;
        logic       hsync;
        logic       vsync;
    } beam_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       de;
        logic       hsync;
        logic       vsync;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } video_t;

    typedef enum logic {
        hold,
        step
    } motion_state_e;

endpackage

/* src/sprite_rom.sv */
// RGB565 sprite ROM
`timescale 1ns/100ps

module sprite_rom
    import sprite_pkg::*;
(
    input  logic                  pix_clk,
    input  logic [rom_addr_w-1:0] rom_addr,
    output logic [15:0]           rom_data
);

    // Frame 0 in the low half, frame 1 in the high half
    logic [15:0] mem [rom_words];

    initial begin
        $readmemh("src/sprite_frames.hex", mem);
    end

    // Registered read, one clock of latency
    always_ff @(posedge pix_clk) begin
        rom_data <= mem[rom_addr];
    end

endmodule

/* verification/sprite_display_tb.sv */
// Sprite display testbench
`timescale 1ns/100ps

module sprite_display_tb
    import sprite_pkg::*;
();

    typedef struct packed {
        logic [31:0] frame;
        logic [9:0]  x;
        logic [9:0]  y;
        logic [7:0]  r;
        logic [7:0]  g;
        logic [7:0]  b;
    } sample_t;

    logic        pix_clk;
    logic        rst_n;
    video_t      video_out;

    sample_t     stim_q[$];
    int          error_count;
    int          check_count;
    int          sample_idx;
    int          watchdog_cycles;
    logic        watchdog_armed;
    logic        stim_ok;
    logic [31:0] frame_num;

    sprite_display_top u_sprite_display_top (
        .pix_clk   (pix_clk),
        .rst_n     (rst_n),
        .video_out (video_out)
    );

    // 100 ns period
    initial begin
        pix_clk = 1'b0;
        forever begin
            #50 pix_clk = ~pix_clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic load_stimulus(output logic ok);
        int      fd;
        int      n;
        int      f;
        int      x;
        int      y;
        int      r;
        int      g;
        int      b;
        string   line;
        sample_t s;
        ok = 1'b0;
        fd = $fopen("verification/sprite_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file verification/sprite_stimulus.txt");
            return;
        end
        // Comment and blank lines scan no fields
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%d %d %d %h %h %h", f, x, y, r, g, b);
            if (n == 6) begin
                s.frame = 32'(f);
                s.x     = 10'(x);
                s.y     = 10'(y);
                s.r     = 8'(r);
                s.g     = 8'(g);
                s.b     = 8'(b);
                stim_q.push_back(s);
            end else if (n > 0) begin
                $display("A stimulus line could not be read: %s", line);
                $fclose(fd);
                return;
            end
        end
        $fclose(fd);
        if (stim_q.size() == 0) begin
            $display("The stimulus file holds no sample points");
        end else begin
            ok = 1'b1;
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge pix_clk);
        #10;
        // Idle output while reset is held
        check_value("video_out.de in reset", 32'(video_out.de), 32'd0);
        check_value("video_out.hsync in reset", 32'(video_out.hsync), 32'd1);
        check_value("video_out.vsync in reset", 32'(video_out.vsync), 32'd1);
        check_value("video_out.r in reset", 32'(video_out.r), 32'd0);
        check_value("video_out.g in reset", 32'(video_out.g), 32'd0);
        check_value("video_out.b in reset", 32'(video_out.b), 32'd0);
        rst_n = 1'b1;
    endtask

    task automatic verify_sample(input sample_t s);
        string where;
        logic  exp_de;
        logic  exp_hsync;
        logic  exp_vsync;
        where     = $sformatf(" at frame %0d (%0d,%0d)", s.frame, s.x, s.y);
        // Sync pulses are active low
        exp_de    = (s.x < h_visible) && (s.y < v_visible);
        exp_hsync = !((s.x >= h_visible + h_front) && (s.x < h_visible + h_front + h_sync));
        exp_vsync = !((s.y >= v_visible + v_front) && (s.y < v_visible + v_front + v_sync));
        check_value({"video_out.de", where}, 32'(video_out.de), 32'(exp_de));
        check_value({"video_out.hsync", where}, 32'(video_out.hsync), 32'(exp_hsync));
        check_value({"video_out.vsync", where}, 32'(video_out.vsync), 32'(exp_vsync));
        check_value({"video_out.r", where}, 32'(video_out.r), 32'(s.r));
        check_value({"video_out.g", where}, 32'(video_out.g), 32'(s.g));
        check_value({"video_out.b", where}, 32'(video_out.b), 32'(s.b));
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        logic [31:0] last_frame;
        logic        prev_vsync;
        logic        live;
        rst_n          = 1'b0;
        error_count    = 0;
        check_count    = 0;
        sample_idx     = 0;
        frame_num      = '0;
        watchdog_armed = 1'b0;
        void'($urandom(32'h7670));
        load_stimulus(stim_ok);
        if (!stim_ok) begin
            error_count++;
        end else begin
            last_frame = '0;
            foreach (stim_q[i]) begin
                if (stim_q[i].frame > last_frame) begin
                    last_frame = stim_q[i].frame;
                end
            end
            // Two spare frames beyond the last sample point
            watchdog_cycles = (int'(last_frame) + 2) * int'(h_total) * int'(v_total);
            watchdog_armed  = 1'b1;
            apply_reset();
            prev_vsync = 1'b1;
            live       = 1'b0;
            while (sample_idx < stim_q.size()) begin
                @(negedge pix_clk);
                // Frame count advances on each falling edge of vsync
                if (prev_vsync && !video_out.vsync) begin
                    frame_num = frame_num + 32'd1;
                end
                prev_vsync = video_out.vsync;
                // Output still holds reset values until the first pixel arrives
                if (video_out.de) begin
                    live = 1'b1;
                end else if (!live) begin
                    check_value("video_out.hsync after reset", 32'(video_out.hsync), 32'd1);
                    check_value("video_out.vsync after reset", 32'(video_out.vsync), 32'd1);
                    check_value("video_out.r after reset", 32'(video_out.r), 32'd0);
                    check_value("video_out.g after reset", 32'(video_out.g), 32'd0);
                    check_value("video_out.b after reset", 32'(video_out.b), 32'd0);
                end
                if (live && frame_num == stim_q[sample_idx].frame
                        && video_out.x == stim_q[sample_idx].x
                        && video_out.y == stim_q[sample_idx].y) begin
                    verify_sample(stim_q[sample_idx]);
                    sample_idx++;
                end
            end
        end
        finish_run();
    end

    // Watchdog
    initial begin
        wait (watchdog_armed);
        repeat (watchdog_cycles) @(posedge pix_clk);
        $display("Timeout: only %0d of %0d stimulus points were reached after %0d clocks",
                 sample_idx, stim_q.size(), watchdog_cycles);
        error_count++;
        finish_run();
    end

endmodule

/* verification/sprite_stimulus.txt */
# Columns: frame x y red green blue
# Frame, x and y in decimal, colours in hex, listed in the order the beam reaches them
# Frame 0 background, blanking and sprite at x 608
0   0   0   88 cc 88
0   700 10  00 00 00
0   799 100 00 00 00
0   607 224 88 cc 88
0   608 224 00 00 ff
0   611 224 00 00 ff
0   612 224 ff ff ff
0   624 224 ff 00 00
0   636 224 88 cc 88
0   607 230 88 cc 88
0   616 236 ff ff 00
0   620 236 84 82 84
0   616 241 00 ff 00
0   608 250 88 cc 88
0   612 250 ff 00 00
0   639 255 88 cc 88
0   620 256 88 cc 88
0   639 479 88 cc 88
0   0   485 00 00 00
# Vertical sync lines count as frame 1
1   320 491 00 00 00
# Frame 1 has moved one pixel left
1   607 224 00 00 ff
# Frame 3, window from 605 to 636
3   604 224 88 cc 88
3   605 224 00 00 ff
3   609 224 ff ff ff
3   636 232 ff 00 00
3   637 232 88 cc 88
3   617 236 84 82 84
# Frame 8 shows animation frame 1 at x 600
8   600 224 ff ff ff
8   604 224 00 00 ff
8   608 232 ff ff ff
8   612 236 4a 4d 4a
8   599 240 88 cc 88
8   631 240 ff 00 00
8   632 240 88 cc 88
8   604 244 4a 4d 4a
